//--- dv/axi_master_bfm.sv
module axi_master_bfm (
    input  logic              clk,
    output axi_pkg::axi_req_t req,
    input  axi_pkg::axi_rsp_t rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    axi_pkg::axi_req_t drv = '0;
    // what the driver is blocked on, shown if the run times out
    string waiting_on = "nothing";

    assign req = drv;

    task automatic do_read(input axi_pkg::addr_t addr, input int stall,
                           output axi_pkg::data_t data, output axi_pkg::resp_t resp,
                           output time done_at);
        drv.ar.addr  = addr;
        drv.ar.valid = 1'b1;
        waiting_on   = "arready";
        do begin
            @(negedge clk);
        end while (!rsp.arready);
        @(posedge clk);
        #1;
        drv.ar.valid = 1'b0;
        waiting_on   = "rvalid";
        do begin
            @(negedge clk);
        end while (!rsp.r.valid);
        // rready held low for a few cycles
        repeat (stall) @(posedge clk);
        @(posedge clk);
        #1;
        drv.rready = 1'b1;
        @(negedge clk);
        data = rsp.r.data;
        resp = rsp.r.resp;
        @(posedge clk);
        done_at = $time;
        #1;
        drv.rready = 1'b0;
        waiting_on = "nothing";
    endtask

    task automatic do_write(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
                            input axi_pkg::strb_t strb, input int stall,
                            output axi_pkg::resp_t resp, output time done_at);
        logic aw_fire;
        logic w_fire;
        drv.aw.addr  = addr;
        drv.aw.valid = 1'b1;
        drv.w.data   = data;
        drv.w.strb   = strb;
        drv.w.valid  = 1'b1;
        waiting_on   = "awready and wready";
        // aw and w may be taken on different edges
        while (drv.aw.valid || drv.w.valid) begin
            @(negedge clk);
            aw_fire = drv.aw.valid && rsp.awready;
            w_fire  = drv.w.valid && rsp.wready;
            @(posedge clk);
            #1;
            if (aw_fire) begin
                drv.aw.valid = 1'b0;
            end
            if (w_fire) begin
                drv.w.valid = 1'b0;
            end
        end
        waiting_on = "bvalid";
        do begin
            @(negedge clk);
        end while (!rsp.b.valid);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        #1;
        drv.bready = 1'b1;
        @(negedge clk);
        resp = rsp.b.resp;
        @(posedge clk);
        done_at = $time;
        #1;
        drv.bready = 1'b0;
        waiting_on = "nothing";
    endtask

endmodule

//--- dv/tb_mem_subsystem.sv
module tb_mem_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    // about 250 transactions of some 8 cycles each, run gets twice that
    localparam int TXN_COUNT  = 250;
    localparam int TXN_CYCLES = 8;
    localparam int MAX_CYCLES = 2 * TXN_COUNT * TXN_CYCLES;

    logic              clk = 1'b0;
    logic              rst_n;
    axi_pkg::axi_req_t m0_req;
    axi_pkg::axi_rsp_t m0_rsp;
    axi_pkg::axi_req_t m1_req;
    axi_pkg::axi_rsp_t m1_rsp;

    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    logic [7:0]        ref_mem [axi_pkg::addr_t];
    axi_pkg::addr_t    used [$];
    axi_pkg::axi_req_t held_req [2];
    axi_pkg::axi_rsp_t held_rsp [2];

    always #10 clk = ~clk;

    mem_subsystem_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_req (m0_req),
        .m0_rsp (m0_rsp),
        .m1_req (m1_req),
        .m1_rsp (m1_rsp)
    );

    axi_master_bfm bfm0 (.clk(clk), .req(m0_req), .rsp(m0_rsp));
    axi_master_bfm bfm1 (.clk(clk), .req(m1_req), .rsp(m1_rsp));

    function automatic logic addr_in_range(input axi_pkg::addr_t addr);
        return addr >= mem_pkg::MEM_BASE
            && addr < mem_pkg::MEM_BASE + 32'(4 * mem_pkg::MEM_WORDS);
    endfunction

    function automatic void model_write(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
                                        input axi_pkg::strb_t strb);
        if (addr_in_range(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    ref_mem[{addr[31:2], 2'b00} + 32'(i)] = data[8*i +: 8];
                end
            end
        end
    endfunction

    function automatic axi_pkg::data_t model_read(input axi_pkg::addr_t addr);
        axi_pkg::data_t word;
        axi_pkg::addr_t base;
        word = '0;
        base = {addr[31:2], 2'b00};
        if (addr_in_range(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (ref_mem.exists(base + 32'(i))) begin
                    word[8*i +: 8] = ref_mem[base + 32'(i)];
                end
            end
        end
        return word;
    endfunction

    function automatic axi_pkg::resp_t expected_resp(input axi_pkg::addr_t addr);
        return addr_in_range(addr) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    endfunction

    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t %s expected %h got %h", $time, sig, exp, got);
        end
    endtask

    task automatic read_and_check(input int m, input axi_pkg::addr_t addr, output time done_at);
        axi_pkg::data_t data;
        axi_pkg::resp_t resp;
        int             stall;
        stall = $urandom_range(3);
        if (m == 0) begin
            bfm0.do_read(addr, stall, data, resp, done_at);
        end else begin
            bfm1.do_read(addr, stall, data, resp, done_at);
        end
        compare_value($sformatf("m%0d_rsp.r.resp", m), 32'(resp), 32'(expected_resp(addr)));
        compare_value($sformatf("m%0d_rsp.r.data", m), data, model_read(addr));
    endtask

    task automatic write_and_check(input int m, input axi_pkg::addr_t addr,
                                   input axi_pkg::data_t data, input axi_pkg::strb_t strb,
                                   output time done_at);
        axi_pkg::resp_t resp;
        int             stall;
        stall = $urandom_range(3);
        if (m == 0) begin
            bfm0.do_write(addr, data, strb, stall, resp, done_at);
        end else begin
            bfm1.do_write(addr, data, strb, stall, resp, done_at);
        end
        compare_value($sformatf("m%0d_rsp.b.resp", m), 32'(resp), 32'(expected_resp(addr)));
        model_write(addr, data, strb);
    endtask

    task automatic check_tie_order(input string dir, input int winner, input time t_m0,
                                   input time t_m1);
        checks++;
        assert ((winner == 0) ? (t_m0 < t_m1) : (t_m1 < t_m0)) else begin
            errors++;
            $display("%s tie before %0t was not granted to m%0d first", dir, $time, winner);
        end
    endtask

    // a stalled response must not move until it is taken
    task automatic check_held(input int m, input axi_pkg::axi_rsp_t now);
        if (held_rsp[m].r.valid && !held_req[m].rready) begin
            compare_value($sformatf("m%0d_rsp.r.valid", m), 32'(now.r.valid), 32'd1);
            compare_value($sformatf("m%0d_rsp.r.data", m), now.r.data, held_rsp[m].r.data);
            compare_value($sformatf("m%0d_rsp.r.resp", m), 32'(now.r.resp),
                          32'(held_rsp[m].r.resp));
        end
        if (held_rsp[m].b.valid && !held_req[m].bready) begin
            compare_value($sformatf("m%0d_rsp.b.valid", m), 32'(now.b.valid), 32'd1);
            compare_value($sformatf("m%0d_rsp.b.resp", m), 32'(now.b.resp),
                          32'(held_rsp[m].b.resp));
        end
    endtask

    always @(negedge clk) begin
        check_held(0, m0_rsp);
        check_held(1, m1_rsp);
        held_req[0] = m0_req;
        held_req[1] = m1_req;
        held_rsp[0] = m0_rsp;
        held_rsp[1] = m1_rsp;
    end

    assert property (@(posedge clk) (cycles > 1 && !rst_n) |=>
        !(m0_rsp.r.valid || m1_rsp.r.valid || m0_rsp.b.valid || m1_rsp.b.valid))
        else begin
            errors++;
            $display("response valid seen at %0t during or right after reset", $time);
        end

    // only the granted master sees its direction
    assert property (@(posedge clk)
        !(m0_rsp.r.valid && m1_rsp.r.valid) && !(m0_rsp.arready && m1_rsp.arready))
        else begin
            errors++;
            $display("read channel active toward both masters at %0t", $time);
        end

    assert property (@(posedge clk)
        !(m0_rsp.b.valid && m1_rsp.b.valid) && !(m0_rsp.awready && m1_rsp.awready)
        && !(m0_rsp.wready && m1_rsp.wready))
        else begin
            errors++;
            $display("write channel active toward both masters at %0t", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout after %0d cycles, m0 waiting on %s, m1 waiting on %s",
                     cycles, bfm0.waiting_on, bfm1.waiting_on);
            $display("checks: %0d errors: %0d", checks, errors + 1);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        time            t0;
        time            t1;
        int             m;
        axi_pkg::addr_t a;
        axi_pkg::addr_t b;
        void'($urandom(42));
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // full words, distinct addresses across the array
        for (int i = 0; i < 30; i++) begin
            a = mem_pkg::MEM_BASE + 32'(4 * (i * 33 + int'($urandom_range(31))));
            used.push_back(a);
            write_and_check($urandom_range(1), a, $urandom, 4'hf, t0);
            read_and_check($urandom_range(1), a, t0);
        end

        for (int i = 0; i < 20; i++) begin
            a = used[$urandom_range(used.size() - 1)];
            write_and_check($urandom_range(1), a, $urandom, 4'($urandom_range(14, 1)), t0);
            read_and_check($urandom_range(1), a, t0);
        end

        // same word index, but above the array or below its base
        for (int i = 0; i < 8; i++) begin
            a = used[$urandom_range(used.size() - 1)];
            b = (i % 2 == 0) ? a + 32'h1000 : a ^ 32'h8000_0000;
            read_and_check($urandom_range(1), b, t0);
            write_and_check($urandom_range(1), b, $urandom, 4'hf, t0);
            read_and_check($urandom_range(1), a, t0);
        end

        for (int i = 0; i < 16; i++) begin
            m = $urandom_range(1);
            read_and_check(m, used[i], t0);
            fork
                read_and_check(0, used[i + 1], t0);
                read_and_check(1, used[i + 2], t1);
            join
            check_tie_order("read", 1 - m, t0, t1);
        end

        for (int i = 0; i < 16; i++) begin
            m = $urandom_range(1);
            write_and_check(m, used[i], $urandom, 4'hf, t0);
            fork
                write_and_check(0, used[i + 1], $urandom, 4'hf, t0);
                write_and_check(1, used[i + 2], $urandom, 4'hf, t1);
            join
            check_tie_order("write", 1 - m, t0, t1);
            read_and_check(m, used[i + 1], t0);
            read_and_check(1 - m, used[i + 2], t1);
        end

        @(posedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_mem_subsystem -f src.f -o tb_sim; then
    echo "build failed"
    exit 1
fi

if ! output=$(./obj_dir/tb_sim 2>&1); then
    echo "$output"
    echo "simulation exited with an error"
    exit 1
fi

echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- source/axi_arbiter.sv
module axi_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  axi_pkg::axi_req_t m0_req,
    output axi_pkg::axi_rsp_t m0_rsp,
    input  axi_pkg::axi_req_t m1_req,
    output axi_pkg::axi_rsp_t m1_rsp,
    output axi_pkg::axi_req_t s_req,
    input  axi_pkg::axi_rsp_t s_rsp
);

    mem_pkg::arb_state_t rd_state;
    mem_pkg::arb_state_t wr_state;
    // granted master, kept as last winner once idle again
    logic                rd_grant;
    logic                wr_grant;

    logic                rd_want0;
    logic                rd_want1;
    logic                wr_want0;
    logic                wr_want1;

    axi_pkg::axi_req_t   rd_src;
    axi_pkg::axi_req_t   wr_src;

    // round robin on a tie, otherwise whoever asks
    function automatic logic pick(logic want0, logic want1, logic last);
        if (want0 && want1) begin
            return !last;
        end
        return want1;
    endfunction

    assign rd_want0 = m0_req.ar.valid;
    assign rd_want1 = m1_req.ar.valid;
    assign wr_want0 = m0_req.aw.valid || m0_req.w.valid;
    assign wr_want1 = m1_req.aw.valid || m1_req.w.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= mem_pkg::ARB_IDLE;
            rd_grant <= 1'b1;
        end else begin
            case (rd_state)
                mem_pkg::ARB_IDLE: begin
                    if (rd_want0 || rd_want1) begin
                        rd_state <= mem_pkg::ARB_BUSY;
                        rd_grant <= pick(rd_want0, rd_want1, rd_grant);
                    end
                end
                mem_pkg::ARB_BUSY: begin
                    if (s_rsp.r.valid && s_req.rready) begin
                        rd_state <= mem_pkg::ARB_IDLE;
                    end
                end
                default: rd_state <= mem_pkg::ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= mem_pkg::ARB_IDLE;
            wr_grant <= 1'b1;
        end else begin
            case (wr_state)
                mem_pkg::ARB_IDLE: begin
                    if (wr_want0 || wr_want1) begin
                        wr_state <= mem_pkg::ARB_BUSY;
                        wr_grant <= pick(wr_want0, wr_want1, wr_grant);
                    end
                end
                mem_pkg::ARB_BUSY: begin
                    if (s_rsp.b.valid && s_req.bready) begin
                        wr_state <= mem_pkg::ARB_IDLE;
                    end
                end
                default: wr_state <= mem_pkg::ARB_IDLE;
            endcase
        end
    end

    assign rd_src = rd_grant ? m1_req : m0_req;
    assign wr_src = wr_grant ? m1_req : m0_req;

    always_comb begin
        s_req  = '0;
        m0_rsp = '0;
        m1_rsp = '0;

        if (rd_state == mem_pkg::ARB_BUSY) begin
            s_req.ar     = rd_src.ar;
            s_req.rready = rd_src.rready;
            if (rd_grant) begin
                m1_rsp.arready = s_rsp.arready;
                m1_rsp.r       = s_rsp.r;
            end else begin
                m0_rsp.arready = s_rsp.arready;
                m0_rsp.r       = s_rsp.r;
            end
        end

        if (wr_state == mem_pkg::ARB_BUSY) begin
            s_req.aw     = wr_src.aw;
            s_req.w      = wr_src.w;
            s_req.bready = wr_src.bready;
            if (wr_grant) begin
                m1_rsp.awready = s_rsp.awready;
                m1_rsp.wready  = s_rsp.wready;
                m1_rsp.b       = s_rsp.b;
            end else begin
                m0_rsp.awready = s_rsp.awready;
                m0_rsp.wready  = s_rsp.wready;
                m0_rsp.b       = s_rsp.b;
            end
        end
    end

endmodule

//--- source/axi_pkg.sv
package axi_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // read address channel
    typedef struct packed {
        addr_t addr;
        logic  valid;
    } ar_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  valid;
    } r_rsp_t;

    typedef struct packed {
        addr_t addr;
        logic  valid;
    } aw_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  valid;
    } w_req_t;

    typedef struct packed {
        resp_t resp;
        logic  valid;
    } b_rsp_t;

    // master side, everything flowing toward the slave
    typedef struct packed {
        ar_req_t ar;
        aw_req_t aw;
        w_req_t  w;
        logic    rready;
        logic    bready;
    } axi_req_t;

    // slave side
    typedef struct packed {
        r_rsp_t r;
        b_rsp_t b;
        logic   arready;
        logic   awready;
        logic   wready;
    } axi_rsp_t;

endpackage

//--- source/axi_sram_slave.sv
module axi_sram_slave (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axi_req_t  req,
    output axi_pkg::axi_rsp_t  rsp,
    output mem_pkg::word_idx_t rd_idx,
    input  axi_pkg::data_t     rd_data,
    output logic               wr_en,
    output mem_pkg::word_idx_t wr_idx,
    output axi_pkg::data_t     wr_data,
    output axi_pkg::strb_t     wr_strb
);

    mem_pkg::rd_state_t rd_state;
    mem_pkg::lat_cnt_t  rd_cnt;
    axi_pkg::addr_t     rd_addr_q;
    axi_pkg::data_t     rd_data_q;
    axi_pkg::resp_t     rd_resp_q;
    logic               rd_done;

    mem_pkg::wr_state_t wr_state;
    mem_pkg::lat_cnt_t  wr_cnt;
    axi_pkg::addr_t     wr_addr_q;
    axi_pkg::data_t     wr_data_q;
    axi_pkg::strb_t     wr_strb_q;
    axi_pkg::resp_t     wr_resp_q;
    logic               aw_got;
    logic               w_got;
    logic               aw_hs;
    logic               w_hs;
    logic               wr_fire;

    function automatic logic in_range(axi_pkg::addr_t addr);
        axi_pkg::addr_t offset;
        offset = addr - mem_pkg::MEM_BASE;
        return offset < axi_pkg::addr_t'(4 * mem_pkg::MEM_WORDS);
    endfunction

    // low two bits dropped, no unaligned access
    function automatic mem_pkg::word_idx_t word_of(axi_pkg::addr_t addr);
        axi_pkg::addr_t offset;
        offset = addr - mem_pkg::MEM_BASE;
        return offset[2 +: $bits(mem_pkg::word_idx_t)];
    endfunction

    always_comb begin
        rsp.arready = (rd_state == mem_pkg::RD_IDLE);
        rsp.r.valid = (rd_state == mem_pkg::RD_RESP);
        rsp.r.data  = rd_data_q;
        rsp.r.resp  = rd_resp_q;
        rsp.awready = (wr_state == mem_pkg::WR_IDLE) && !aw_got;
        rsp.wready  = (wr_state == mem_pkg::WR_IDLE) && !w_got;
        rsp.b.valid = (wr_state == mem_pkg::WR_RESP);
        rsp.b.resp  = wr_resp_q;
    end

    // read side
    assign rd_done = (rd_state == mem_pkg::RD_WAIT) && (rd_cnt == mem_pkg::READ_LATENCY);
    assign rd_idx  = word_of(rd_addr_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= mem_pkg::RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                mem_pkg::RD_IDLE: begin
                    if (req.ar.valid) begin
                        rd_state <= mem_pkg::RD_WAIT;
                        rd_cnt   <= '0;
                    end
                end
                mem_pkg::RD_WAIT: begin
                    if (rd_done) begin
                        rd_state <= mem_pkg::RD_RESP;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                mem_pkg::RD_RESP: begin
                    if (req.rready) begin
                        rd_state <= mem_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= mem_pkg::RD_IDLE;
            endcase
        end
    end

    // word is latched so it stays put while rready is low
    always_ff @(posedge clk) begin
        if (rsp.arready && req.ar.valid) begin
            rd_addr_q <= req.ar.addr;
        end
        if (rd_done) begin
            rd_data_q <= in_range(rd_addr_q) ? rd_data : '0;
            rd_resp_q <= in_range(rd_addr_q) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

    // write side, aw and w in either order
    assign aw_hs   = req.aw.valid && rsp.awready;
    assign w_hs    = req.w.valid && rsp.wready;
    assign wr_fire = (wr_state == mem_pkg::WR_WAIT) && (wr_cnt == mem_pkg::WRITE_LATENCY);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= mem_pkg::WR_IDLE;
            wr_cnt   <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            case (wr_state)
                mem_pkg::WR_IDLE: begin
                    if ((aw_got || aw_hs) && (w_got || w_hs)) begin
                        wr_state <= mem_pkg::WR_WAIT;
                        wr_cnt   <= '0;
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                    end else begin
                        if (aw_hs) begin
                            aw_got <= 1'b1;
                        end
                        if (w_hs) begin
                            w_got <= 1'b1;
                        end
                    end
                end
                mem_pkg::WR_WAIT: begin
                    if (wr_fire) begin
                        wr_state <= mem_pkg::WR_RESP;
                    end else begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                end
                mem_pkg::WR_RESP: begin
                    if (req.bready) begin
                        wr_state <= mem_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= mem_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_addr_q <= req.aw.addr;
        end
        if (w_hs) begin
            wr_data_q <= req.w.data;
            wr_strb_q <= req.w.strb;
        end
        if (wr_fire) begin
            wr_resp_q <= in_range(wr_addr_q) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

    // out of range writes are dropped here
    assign wr_en   = wr_fire && in_range(wr_addr_q);
    assign wr_idx  = word_of(wr_addr_q);
    assign wr_data = wr_data_q;
    assign wr_strb = wr_strb_q;

endmodule

//--- source/mem_pkg.sv
package mem_pkg;

    localparam int MEM_WORDS = 1024;

    typedef logic [$clog2(MEM_WORDS)-1:0] word_idx_t;

    // array sits at this byte address on the bus
    localparam axi_pkg::addr_t MEM_BASE = 32'h8000_0000;

    typedef logic [2:0] lat_cnt_t;

    localparam lat_cnt_t READ_LATENCY  = 3'd2;
    localparam lat_cnt_t WRITE_LATENCY = 3'd1;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WAIT,
        WR_RESP
    } wr_state_t;

    // one per direction in the arbiter
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

//--- source/mem_subsystem_top.sv
module mem_subsystem_top (
    input  logic              clk,
    input  logic              rst_n,
    input  axi_pkg::axi_req_t m0_req,
    output axi_pkg::axi_rsp_t m0_rsp,
    input  axi_pkg::axi_req_t m1_req,
    output axi_pkg::axi_rsp_t m1_rsp
);

    axi_pkg::axi_req_t  s_req;
    axi_pkg::axi_rsp_t  s_rsp;

    mem_pkg::word_idx_t rd_idx;
    axi_pkg::data_t     rd_data;
    logic               wr_en;
    mem_pkg::word_idx_t wr_idx;
    axi_pkg::data_t     wr_data;
    axi_pkg::strb_t     wr_strb;

    axi_arbiter arb0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_req (m0_req),
        .m0_rsp (m0_rsp),
        .m1_req (m1_req),
        .m1_rsp (m1_rsp),
        .s_req  (s_req),
        .s_rsp  (s_rsp)
    );

    axi_sram_slave slave0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (s_req),
        .rsp     (s_rsp),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

    sram_array array0 (
        .clk     (clk),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

endmodule

//--- source/sram_array.sv
module sram_array (
    input  logic               clk,
    input  mem_pkg::word_idx_t rd_idx,
    output axi_pkg::data_t     rd_data,
    input  logic               wr_en,
    input  mem_pkg::word_idx_t wr_idx,
    input  axi_pkg::data_t     wr_data,
    input  axi_pkg::strb_t     wr_strb
);

    localparam int LANES = $bits(axi_pkg::strb_t);

    axi_pkg::data_t mem [mem_pkg::MEM_WORDS];

    // registered read, data follows the index by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

    // byte lane merge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- src.f
source/axi_pkg.sv
source/mem_pkg.sv
source/sram_array.sv
source/axi_sram_slave.sv
source/axi_arbiter.sv
source/mem_subsystem_top.sv
dv/axi_master_bfm.sv
dv/tb_mem_subsystem.sv
